/* source/icachePkg.sv */
//////////////////////////////////////////////////////////////////////
// geometry of the direct-mapped instruction cache, 16 lines of 4 words
// fetch and bus addresses are byte addresses, lines are 16-byte aligned
//////////////////////////////////////////////////////////////////////

package icachePkg;

   // address and data widths
   localparam int AddrWidth = 32;
   localparam int WordWidth = 32;

   // cache shape
   localparam int LineWords = 4;
   localparam int NumLines = 16;

   // address split: tag | index | byte offset
   localparam int OffsetBits = 4;
   localparam int IndexBits = 4;
   localparam int TagBits = AddrWidth - IndexBits - OffsetBits;

   //////////////////////////////////////////////////////////////////////
   // one cache line, two views of the same 128 bits
   //////////////////////////////////////////////////////////////////////

   // words for the refill path, one per APB beat
   // halves for instruction alignment, compressed code is halfword based
   typedef union packed {
      logic [LineWords-1:0][WordWidth-1:0] words;
      logic [2*LineWords-1:0][WordWidth/2-1:0] halves;
   } icacheLine_u;

endpackage

/* source/refillCounter.sv */
//////////////////////////////////////////////////////////////////////
// refill beat counter, wraps after the fourth word of a line
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module refillCounter (
   input  logic       clk,
   input  logic       reset,
   input  logic       cntClear,
   input  logic       cntEn,
   output logic [1:0] beat,
   output logic       lastBeat
);

   // clear wins over count
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat <= 2'd0;
      end else if (cntClear) begin
         beat <= 2'd0;
      end else if (cntEn) begin
         beat <= beat + 2'd1;
      end
   end

   // final word of the line
   assign lastBeat = (beat == 2'd3);

endmodule

/* source/apbFetchRequester.sv */
//////////////////////////////////////////////////////////////////////
// APB requester, one word read per request, no error response
// fetchAck and fetchData are valid only in the completing access cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apbFetchRequester (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           fetchReq,
   input  logic [icachePkg::AddrWidth-1:0] lineAddr,
   input  logic [1:0]                     beat,
   input  logic [icachePkg::WordWidth-1:0] prdata,
   input  logic                           pready,
   output logic [icachePkg::AddrWidth-1:0] paddr,
   output logic                           psel,
   output logic                           penable,
   output logic                           pwrite,
   output logic                           fetchAck,
   output logic [icachePkg::WordWidth-1:0] fetchData
);

   typedef enum logic [1:0] {Idle, Setup, Access} apbPhase_e;

   apbPhase_e phase;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         phase <= Idle;
      end else begin
         case (phase)
            Idle: phase <= fetchReq ? Setup : Idle;
            Setup: phase <= Access;
            // stay in access through the wait states
            Access: phase <= pready ? Idle : Access;
            default: phase <= Idle;
         endcase
      end
   end

   // word address from line base and beat, held by the counter for the transfer
   assign paddr = {lineAddr[icachePkg::AddrWidth-1:icachePkg::OffsetBits], beat, 2'b00};
   assign psel = (phase != Idle);
   assign penable = (phase == Access);
   // read only
   assign pwrite = 1'b0;

   assign fetchAck = (phase == Access) && pready;
   assign fetchData = prdata;

endmodule

/* source/icacheArray.sv */
//////////////////////////////////////////////////////////////////////
// tag, valid and data arrays in flops, combinational read
// a refill line is assembled in a buffer and written whole on lineWrite
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icacheArray (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [icachePkg::AddrWidth-1:0] pc,
   input  logic                            selNext,
   input  logic [1:0]                      beat,
   input  logic                            fetchAck,
   input  logic [icachePkg::WordWidth-1:0] fetchData,
   input  logic                            lineWrite,
   output logic [icachePkg::AddrWidth-1:0] lineAddr,
   output logic                            hit,
   output logic                            spill,
   output icachePkg::icacheLine_u          line
);

   localparam int LineNumBits = icachePkg::AddrWidth - icachePkg::OffsetBits;

   logic [LineNumBits-1:0]         lineNum;
   logic [icachePkg::IndexBits-1:0] index;
   logic [icachePkg::TagBits-1:0]   tag;

   logic [icachePkg::TagBits-1:0] tagArr [icachePkg::NumLines];
   icachePkg::icacheLine_u        dataArr [icachePkg::NumLines];
   logic [icachePkg::NumLines-1:0] validArr;
   icachePkg::icacheLine_u        refillBuf;

   // current line or the one after it for the upper half of a spill
   assign lineNum = pc[icachePkg::AddrWidth-1:icachePkg::OffsetBits]
                    + {{(LineNumBits-1){1'b0}}, selNext};
   assign lineAddr = {lineNum, {icachePkg::OffsetBits{1'b0}}};
   assign index = lineNum[icachePkg::IndexBits-1:0];
   assign tag = lineNum[LineNumBits-1:icachePkg::IndexBits];

   // lookup
   assign hit = validArr[index] && (tagArr[index] == tag);
   assign line = dataArr[index];

   // last halfword of a line, upper half lives in the next line
   assign spill = &pc[icachePkg::OffsetBits-1:1];

   //////////////////////////////////////////////////////////////////////
   // refill
   //////////////////////////////////////////////////////////////////////

   // one word per beat through the word view
   always_ff @(posedge clk) begin
      if (fetchAck) begin
         refillBuf.words[beat] <= fetchData;
      end
      if (lineWrite) begin
         dataArr[index] <= refillBuf;
         tagArr[index] <= tag;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         validArr <= '0;
      end else if (lineWrite) begin
         validArr[index] <= 1'b1;
      end
   end

endmodule

/* source/spillAlign.sv */
//////////////////////////////////////////////////////////////////////
// picks the 32-bit instruction from the halfword view of a line
// a spill joins the saved last halfword with halfword 0 of the next line
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spillAlign (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [icachePkg::AddrWidth-1:0] pc,
   input  icachePkg::icacheLine_u          line,
   input  logic                            spillSave,
   input  logic                            useSpill,
   output logic [icachePkg::WordWidth-1:0] instr
);

   localparam int HalfWidth = icachePkg::WordWidth / 2;

   logic [2:0]           hwLo;
   logic [2:0]           hwHi;
   logic [HalfWidth-1:0] savedHalf;

   // halfword position of pc within the line
   assign hwLo = pc[icachePkg::OffsetBits-1:1];
   // wraps at 7, only meaningful with useSpill then
   assign hwHi = hwLo + 3'd1;

   // lower half of a spilled instruction, from the first line
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         savedHalf <= '0;
      end else if (spillSave) begin
         savedHalf <= line.halves[7];
      end
   end

   always_comb begin
      if (useSpill) begin
         instr = {line.halves[0], savedHalf};
      end else begin
         instr = {line.halves[hwHi], line.halves[hwLo]};
      end
   end

endmodule

/* source/icacheCtrl.sv */
//////////////////////////////////////////////////////////////////////
// cache control FSM, outputs are decoded from the state and the inputs
// pc must stay put while icacheStall is high or stallF is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icacheCtrl (
   input  logic clk,
   input  logic reset,
   input  logic stallF,
   input  logic hit,
   input  logic spill,
   input  logic fetchAck,
   input  logic lastBeat,
   output logic fetchReq,
   output logic cntClear,
   output logic cntEn,
   output logic selNext,
   output logic lineWrite,
   output logic spillSave,
   output logic useSpill,
   output logic icacheStall
);

   typedef enum logic [3:0] {
      Ready,
      HitSpill,
      HitSpillFetch,
      HitSpillWrite,
      SpillFinal,
      MissFetch,
      MissWrite,
      MissRead,
      SpillFetch,
      SpillWrite,
      SpillRead,
      SpillSecond,
      CpuBusy,
      CpuBusySpill
   } ctrlState_e;

   ctrlState_e state;
   ctrlState_e nextState;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= Ready;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      fetchReq = 1'b0;
      cntClear = 1'b0;
      cntEn = 1'b0;
      selNext = 1'b0;
      lineWrite = 1'b0;
      spillSave = 1'b0;
      useSpill = 1'b0;
      icacheStall = 1'b1;

      case (state)
         //////////////////////////////////////////////////////////////////////
         // idle, look up the line at pc
         //////////////////////////////////////////////////////////////////////
         Ready: begin
            if (hit && !spill) begin
               // aligned hit, delivered in this cycle
               icacheStall = 1'b0;
               if (stallF) begin
                  nextState = CpuBusy;
               end
            end else if (hit) begin
               // first line present, keep its last halfword
               spillSave = 1'b1;
               nextState = HitSpill;
            end else begin
               cntClear = 1'b1;
               nextState = spill ? SpillFetch : MissFetch;
            end
         end

         // second line of a spill, first half already saved
         HitSpill: begin
            selNext = 1'b1;
            if (hit) begin
               nextState = SpillFinal;
            end else begin
               cntClear = 1'b1;
               nextState = HitSpillFetch;
            end
         end
         HitSpillFetch: begin
            selNext = 1'b1;
            fetchReq = 1'b1;
            cntEn = fetchAck;
            if (fetchAck && lastBeat) begin
               nextState = HitSpillWrite;
            end
         end
         HitSpillWrite: begin
            selNext = 1'b1;
            lineWrite = 1'b1;
            nextState = SpillFinal;
         end

         // saved halfword joined with halfword 0 of the next line
         SpillFinal: begin
            selNext = 1'b1;
            useSpill = 1'b1;
            icacheStall = 1'b0;
            nextState = stallF ? CpuBusySpill : Ready;
         end

         //////////////////////////////////////////////////////////////////////
         // aligned miss
         //////////////////////////////////////////////////////////////////////
         MissFetch: begin
            fetchReq = 1'b1;
            cntEn = fetchAck;
            if (fetchAck && lastBeat) begin
               nextState = MissWrite;
            end
         end
         MissWrite: begin
            lineWrite = 1'b1;
            nextState = MissRead;
         end
         // re-read the new line, Ready then hits and delivers
         MissRead: begin
            nextState = Ready;
         end

         //////////////////////////////////////////////////////////////////////
         // spill with the first line missing
         //////////////////////////////////////////////////////////////////////
         SpillFetch: begin
            fetchReq = 1'b1;
            cntEn = fetchAck;
            if (fetchAck && lastBeat) begin
               nextState = SpillWrite;
            end
         end
         SpillWrite: begin
            lineWrite = 1'b1;
            nextState = SpillRead;
         end
         SpillRead: begin
            spillSave = 1'b1;
            nextState = SpillSecond;
         end
         // second line may still miss, share the refill path of HitSpill
         SpillSecond: begin
            selNext = 1'b1;
            if (hit) begin
               nextState = SpillFinal;
            end else begin
               cntClear = 1'b1;
               nextState = HitSpillFetch;
            end
         end

         // cpu stalled after delivery, instr held
         CpuBusy: begin
            icacheStall = 1'b0;
            if (!stallF) begin
               nextState = Ready;
            end
         end
         CpuBusySpill: begin
            selNext = 1'b1;
            useSpill = 1'b1;
            icacheStall = 1'b0;
            if (!stallF) begin
               nextState = Ready;
            end
         end

         default: begin
            nextState = Ready;
         end
      endcase
   end

endmodule

/* source/icacheTop.sv */
//////////////////////////////////////////////////////////////////////
// instruction cache top, CPU fetch port and APB requester port
// instr is valid whenever icacheStall is low, pwrite is tied low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icacheTop (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [icachePkg::AddrWidth-1:0] pc,
   input  logic                            stallF,
   input  logic [icachePkg::WordWidth-1:0] prdata,
   input  logic                            pready,
   output logic [icachePkg::WordWidth-1:0] instr,
   output logic                            icacheStall,
   output logic [icachePkg::AddrWidth-1:0] paddr,
   output logic                            psel,
   output logic                            penable,
   output logic                            pwrite
);

   // control
   logic fetchReq;
   logic cntClear;
   logic cntEn;
   logic selNext;
   logic lineWrite;
   logic spillSave;
   logic useSpill;

   // status back to control
   logic hit;
   logic spill;
   logic fetchAck;
   logic lastBeat;

   // datapath
   logic [1:0]                      beat;
   logic [icachePkg::AddrWidth-1:0] lineAddr;
   logic [icachePkg::WordWidth-1:0] fetchData;
   icachePkg::icacheLine_u          line;

   icacheCtrl i_ctrl (
      .clk(clk), .reset(reset), .stallF(stallF), .hit(hit), .spill(spill),
      .fetchAck(fetchAck), .lastBeat(lastBeat), .fetchReq(fetchReq),
      .cntClear(cntClear), .cntEn(cntEn), .selNext(selNext), .lineWrite(lineWrite),
      .spillSave(spillSave), .useSpill(useSpill), .icacheStall(icacheStall)
   );

   refillCounter i_counter (
      .clk(clk), .reset(reset), .cntClear(cntClear), .cntEn(cntEn),
      .beat(beat), .lastBeat(lastBeat)
   );

   apbFetchRequester i_apb (
      .clk(clk), .reset(reset), .fetchReq(fetchReq), .lineAddr(lineAddr),
      .beat(beat), .prdata(prdata), .pready(pready), .paddr(paddr), .psel(psel),
      .penable(penable), .pwrite(pwrite), .fetchAck(fetchAck), .fetchData(fetchData)
   );

   icacheArray i_array (
      .clk(clk), .reset(reset), .pc(pc), .selNext(selNext), .beat(beat),
      .fetchAck(fetchAck), .fetchData(fetchData), .lineWrite(lineWrite),
      .lineAddr(lineAddr), .hit(hit), .spill(spill), .line(line)
   );

   spillAlign i_align (
      .clk(clk), .reset(reset), .pc(pc), .line(line), .spillSave(spillSave),
      .useSpill(useSpill), .instr(instr)
   );

endmodule

/* tests/icacheChecker.sv */
//////////////////////////////////////////////////////////////////////
// compares delivered instructions and APB reads with the golden records
// samples on the falling edge, DUT inputs only move on the rising edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icacheChecker (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [icachePkg::AddrWidth-1:0] pc,
   input  logic                            stallF,
   input  logic [icachePkg::WordWidth-1:0] instr,
   input  logic                            icacheStall,
   input  logic [icachePkg::AddrWidth-1:0] paddr,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic                            pready,
   input  logic                            fetchActive,
   input  int                              fetchIdx,
   input  logic [31:0]                     expInstr,
   input  int                              expXfers,
   output int                              fetchCount,
   output int                              failCount,
   output int                              errorCount
);

   localparam int LineNumBits = icachePkg::AddrWidth - icachePkg::OffsetBits;

   int                     xferCount = 0;
   int                     fetchErrors = 0;
   int                     stallCycles = 0;
   int                     expStall;
   logic [LineNumBits-1:0] refillBase;

   initial begin
      fetchCount = 0;
      failCount = 0;
      errorCount = 0;
   end

   task automatic reportValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      errorCount++;
      fetchErrors++;
   endtask

   always @(negedge clk) begin
      if (reset) begin
         if (psel || penable) begin
            $display("APB bus active at %0t while reset is asserted", $time);
            errorCount++;
         end
      end else if (fetchActive) begin
         // the bus is read only
         if (psel && pwrite !== 1'b0) begin
            reportValue("pwrite", 32'd0, {31'd0, pwrite});
         end
         // completed read, a refill walks its line word by word
         if (psel && penable && pready) begin
            if (xferCount % 4 == 0) begin
               refillBase = paddr[icachePkg::AddrWidth-1:icachePkg::OffsetBits];
               if (refillBase != pc[31:4] && refillBase != pc[31:4] + 1) begin
                  $display("refill at %0t reads a line that is not at pc or after it", $time);
                  errorCount++;
                  fetchErrors++;
               end
            end
            if (paddr != {refillBase, xferCount[1:0], 2'b00}) begin
               reportValue("paddr", {refillBase, xferCount[1:0], 2'b00}, paddr);
            end
            xferCount++;
         end
         if (icacheStall) begin
            stallCycles++;
         end
         // cpu holding a delivered instruction
         if (!icacheStall && stallF && psel) begin
            $display("APB read started at %0t while the CPU held its instruction", $time);
            errorCount++;
            fetchErrors++;
         end
         if (!icacheStall && instr !== expInstr) begin
            reportValue("instr", expInstr, instr);
         end
         // fetch ends when the CPU takes the instruction
         if (!icacheStall && !stallF) begin
            if (xferCount != expXfers) begin
               reportValue("APB read count", expXfers, xferCount);
            end
            // aligned hit at once, spill hit one cycle per line
            expStall = (pc[3:0] == 4'he) ? 2 : 0;
            if (expXfers == 0 && stallCycles != expStall) begin
               reportValue("icacheStall cycles", expStall, stallCycles);
            end
            $display("fetch %0d pc %h instr %h reads %0d %s", fetchIdx, pc, instr, xferCount,
                     (fetchErrors == 0) ? "ok" : "mismatch");
            fetchCount++;
            if (fetchErrors != 0) begin
               failCount++;
            end
            xferCount = 0;
            fetchErrors = 0;
            stallCycles = 0;
         end
      end
   end

endmodule

/* tests/icacheAsserts.sv */
//////////////////////////////////////////////////////////////////////
// APB requester protocol checks, bound into icacheTop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icacheAsserts (
   input logic                            clk,
   input logic                            reset,
   input logic [icachePkg::AddrWidth-1:0] paddr,
   input logic                            psel,
   input logic                            penable
);

   // number of failed checks
   int assertFails = 0;

   // a transfer opens with its setup cycle
   pselRise: assert property (@(posedge clk) disable iff (reset) $rose(psel) |-> !penable)
      else begin
         $error("psel rose with penable high");
         assertFails++;
      end

   // address held from setup to the last access cycle
   paddrStable: assert property (@(posedge clk) disable iff (reset)
                                 psel && $past(psel) |-> $stable(paddr))
      else begin
         $error("paddr changed during a transfer");
         assertFails++;
      end

   resetIdle: assert property (@(posedge clk) reset |-> !psel && !penable)
      else begin
         $error("APB bus active in reset");
         assertFails++;
      end

endmodule

bind icacheTop icacheAsserts i_asserts (
   .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable)
);

/* tests/icacheTb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for icacheTop, stimulus and expected values from the golden file
// memory image covers bytes below 0x400, other addresses read a fill pattern
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icacheTb;

   localparam int MaxFetches = 64;
   localparam int MemWords = 256;

   logic                            clk;
   logic                            reset;
   logic [icachePkg::AddrWidth-1:0] pc;
   logic                            stallF;
   logic [icachePkg::WordWidth-1:0] prdata;
   logic                            pready;
   logic [icachePkg::WordWidth-1:0] instr;
   logic                            icacheStall;
   logic [icachePkg::AddrWidth-1:0] paddr;
   logic                            psel;
   logic                            penable;
   logic                            pwrite;

   // expectations handed to the checker, updated with pc
   logic        fetchActive;
   int          fetchIdx;
   logic [31:0] expInstr;
   int          expXfers;
   int          fetchCount;
   int          failCount;
   int          errorCount;

   // golden records
   logic [31:0] memWords [MemWords];
   logic [31:0] fetchPc [MaxFetches];
   int          fetchStall [MaxFetches];
   logic [31:0] fetchInstr [MaxFetches];
   int          fetchXfers [MaxFetches];
   int          numFetches;
   logic        goldenBad;
   logic        loaded = 1'b0;

   // APB memory model, next cycle decided mid-cycle
   int unsigned seed;
   int          waitLeft;
   logic        readyNext;
   logic [31:0] dataNext;

   icacheTop i_dut (
      .clk(clk), .reset(reset), .pc(pc), .stallF(stallF), .prdata(prdata),
      .pready(pready), .instr(instr), .icacheStall(icacheStall), .paddr(paddr),
      .psel(psel), .penable(penable), .pwrite(pwrite)
   );

   icacheChecker i_checker (
      .clk(clk), .reset(reset), .pc(pc), .stallF(stallF), .instr(instr),
      .icacheStall(icacheStall), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pready(pready), .fetchActive(fetchActive), .fetchIdx(fetchIdx),
      .expInstr(expInstr), .expXfers(expXfers), .fetchCount(fetchCount),
      .failCount(failCount), .errorCount(errorCount)
   );

   always #5 clk = ~clk;

   // every bit of the address shows up in the word
   function automatic logic [31:0] fillWord(input logic [31:0] addr);
      fillWord = {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   function automatic logic [31:0] memRead(input logic [31:0] addr);
      if (addr < MemWords * 4) begin
         memRead = memWords[addr[9:2]];
      end else begin
         memRead = fillWord(addr);
      end
   endfunction

   task automatic loadGolden();
      int              fd;
      int              code;
      logic [8*8-1:0]   tok;
      logic [8*160-1:0] rest;
      logic [31:0]      f0, f1, f2, f3, f4;
      for (int i = 0; i < MemWords; i++) begin
         memWords[i] = fillWord(i * 4);
      end
      numFetches = 0;
      goldenBad = 1'b0;
      fd = $fopen("tests/icacheGolden.txt", "r");
      if (fd == 0) begin
         $display("could not open tests/icacheGolden.txt");
         goldenBad = 1'b1;
      end else begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "M") begin
               // line base then its four words
               code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
               goldenBad = goldenBad || (code != 5);
               memWords[f0[9:2]] = f1;
               memWords[f0[9:2] + 1] = f2;
               memWords[f0[9:2] + 2] = f3;
               memWords[f0[9:2] + 3] = f4;
            end else if (tok == "F" && numFetches < MaxFetches) begin
               code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
               goldenBad = goldenBad || (code != 4);
               fetchPc[numFetches] = f0;
               fetchStall[numFetches] = f1;
               fetchInstr[numFetches] = f2;
               fetchXfers[numFetches] = f3;
               numFetches++;
            end else begin
               // comment, drop the rest of the line
               code = $fgets(rest, fd);
            end
         end
         $fclose(fd);
      end
   endtask

   // present one fetch, hold stallF for the record's cycles after delivery
   task automatic runFetch(input int idx);
      int   held;
      logic done;
      held = 0;
      done = 1'b0;
      pc <= fetchPc[idx];
      stallF <= (fetchStall[idx] != 0);
      fetchActive <= 1'b1;
      fetchIdx <= idx;
      expInstr <= fetchInstr[idx];
      expXfers <= fetchXfers[idx];
      while (!done) begin
         @(negedge clk);
         if (!icacheStall && !stallF) begin
            done = 1'b1;
         end else if (!icacheStall) begin
            held++;
            if (held >= fetchStall[idx]) begin
               @(posedge clk);
               stallF <= 1'b0;
            end
         end
      end
      // pc may move on this edge
      @(posedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // APB slave with 0 to 3 wait states per read
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (psel && !penable) begin
         waitLeft = $urandom % 4;
         readyNext = (waitLeft == 0);
         dataNext = memRead(paddr);
      end else if (psel && penable && !pready) begin
         waitLeft = waitLeft - 1;
         readyNext = (waitLeft == 0);
      end else begin
         readyNext = 1'b0;
      end
   end

   always @(posedge clk) begin
      pready <= readyNext;
      prdata <= readyNext ? dataNext : '0;
   end

   initial begin
      seed = 32'hb9a6_5dc2;
      void'($urandom(seed));
      clk = 1'b0;
      reset = 1'b1;
      pc = '0;
      stallF = 1'b0;
      prdata = '0;
      pready = 1'b0;
      fetchActive = 1'b0;
      fetchIdx = 0;
      expInstr = '0;
      expXfers = 0;
      waitLeft = 0;
      readyNext = 1'b0;
      dataNext = '0;
      loadGolden();
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < numFetches; i++) begin
         runFetch(i);
      end
      fetchActive <= 1'b0;
      @(posedge clk);
      $display("fetches %0d of %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
               fetchCount, numFetches, fetchCount - failCount, failCount, errorCount,
               i_dut.i_asserts.assertFails);
      if (numFetches == 0 || goldenBad || fetchCount != numFetches || failCount != 0
          || errorCount != 0 || i_dut.i_asserts.assertFails != 0) begin
         if (numFetches == 0 || goldenBad) begin
            $display("the golden file is missing, empty or has a malformed record");
         end
         $display("*** FAILED ***");
      end else begin
         $display("*** PASSED ***");
      end
      $finish;
   end

   // worst spill refill stays well below 60 cycles
   initial begin
      wait (loaded);
      repeat (numFetches * 60 + 3) @(posedge clk);
      $display("run timed out after %0d cycles, a fetch was never delivered", numFetches * 60 + 3);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

/* tests/icacheGolden.txt */
# memory record: M <line byte address> <word 0> <word 1> <word 2> <word 3>
# fetch record: F <pc> <stallF cycles after delivery> <expected instr> <expected APB reads>
M 00000000 a002a000 a006a004 a00aa008 a00ea00c
M 00000010 a012a010 a016a014 a01aa018 a01ea01c
M 00000020 a022a020 a026a024 a02aa028 a02ea02c
M 00000030 a032a030 a036a034 a03aa038 a03ea03c
M 00000040 a042a040 a046a044 a04aa048 a04ea04c
M 00000050 a052a050 a056a054 a05aa058 a05ea05c
M 00000100 a102a100 a106a104 a10aa108 a10ea10c
# cold miss then hits on the resident line, the last one held by the CPU
F 00000004 0 a006a004 4
F 00000006 0 a008a006 0
F 00000004 3 a006a004 0
# spills with second missing, both missing, first missing, both hitting
F 0000000e 0 a010a00e 4
F 0000002e 0 a030a02e 8
F 00000054 0 a056a054 4
F 0000004e 0 a050a04e 4
F 0000002e 2 a030a02e 0
# index 0 alternates between two tags
F 00000100 0 a102a100 4
F 00000004 0 a006a004 4
F 0000010c 1 a10ea10c 4
F 0000001c 0 a01ea01c 0

/* filelist.f */
source/icachePkg.sv
source/refillCounter.sv
source/apbFetchRequester.sv
source/icacheArray.sv
source/spillAlign.sv
source/icacheCtrl.sv
source/icacheTop.sv
tests/icacheChecker.sv
tests/icacheAsserts.sv
tests/icacheTb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - source/icachePkg.sv
  - source/refillCounter.sv
  - source/apbFetchRequester.sv
  - source/icacheArray.sv
  - source/spillAlign.sv
  - source/icacheCtrl.sv
  - source/icacheTop.sv
  - target: test
    files:
      - tests/icacheChecker.sv
      - tests/icacheAsserts.sv
      - tests/icacheTb.sv
